// File: list.f
rv_core_pkg.sv
reg_file.sv
inst_decode.sv
exec_unit.sv
pc_unit.sv
rv_core_top.sv
tb_rv_core.sv

// File: tb_rv_core.sv
module tb_rv_core;

  logic        clk;
  logic        reset;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        rd_wen;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        halt;

  // slot n of the instruction image holds the word at reset_pc + 4n
  logic [31:0] image [0:255];
  // register model that follows every observed write
  logic [31:0] model [0:31];
  integer      errors;
  integer      timeouts;
  integer      seed;

  rv_core_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .inst    (inst),
    .pc      (pc),
    .rd_wen  (rd_wen),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .halt    (halt)
  );

  always #10 clk = ~clk;

  // instruction encoders with funct3 zero for everything in scope
  function automatic logic [31:0] i_type(rv_core_pkg::opcode_t op, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] imm);
    i_type = {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic logic [31:0] u_type(rv_core_pkg::opcode_t op, logic [4:0] rd,
                                         logic [19:0] imm);
    u_type = {imm, rd, op};
  endfunction

  // offset bit 0 is implicit
  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] off);
    j_type = {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::op_jal};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    sext12 = {{20{imm[11]}}, imm};
  endfunction

  // nop outside the image or while pc is unknown
  function automatic logic [31:0] image_word(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - rv_core_pkg::reset_pc;
    if ($isunknown(addr) || offset >= 32'd1024) begin
      image_word = i_type(rv_core_pkg::op_imm, 5'd0, 5'd0, 12'd0);
    end else begin
      image_word = image[offset[9:2]];
    end
  endfunction

  task automatic place(input logic [31:0] addr, input logic [31:0] word);
    logic [31:0] offset;
    offset = addr - rv_core_pkg::reset_pc;
    image[offset[9:2]] = word;
  endtask

  // inst follows pc shortly after each edge
  always @(posedge clk) begin
    #1;
    inst = image_word(pc);
  end

  // writes are stable mid cycle and commit at the next edge
  always @(negedge clk) begin
    if (!reset && rd_wen) begin
      model[rd_addr] = rd_data;
    end
  end

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: actual %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic expect_write(input logic wen, input logic [4:0] addr,
                              input logic [31:0] data);
    compare("rd_wen", rd_wen, wen);
    if (wen) begin
      compare("rd_addr", rd_addr, addr);
      compare("rd_data", rd_data, data);
    end
  endtask

  // land mid cycle after inst has been driven
  task automatic next_cycle();
    @(posedge clk);
    #4;
  endtask

  task automatic advance_to(input logic [31:0] expected_pc);
    next_cycle();
    compare("pc", pc, expected_pc);
  endtask

  task automatic wait_for_pc(input logic [31:0] addr);
    integer n;
    n = 0;
    while (pc !== addr && n < 200) begin
      next_cycle();
      n++;
    end
    if (pc !== addr) begin
      $display("timeout: pc did not reach %h within 200 cycles", addr);
      timeouts++;
    end
  endtask

  task automatic reset_state();
    integer i;
    compare("pc", pc, rv_core_pkg::reset_pc);
    compare("halt", halt, 1'b0);
    // the nop image gives no writes and a plain walk by four
    for (i = 1; i <= 4; i++) begin
      compare("rd_wen", rd_wen, 1'b0);
      advance_to(rv_core_pkg::reset_pc + 4 * i);
    end
  endtask

  task automatic addi_chain();
    logic [31:0]     base;
    logic [11:0]     imm [0:4];
    logic [4:0][4:0] rd;
    logic [4:0][4:0] rs1;
    integer          r;
    integer          i;
    base = pc + 8;
    // x5 chain then a write to x0 and a read of x0
    rd  = {5'd6, 5'd0, 5'd5, 5'd5, 5'd5};
    rs1 = {5'd0, 5'd5, 5'd5, 5'd5, 5'd0};
    for (i = 0; i < 5; i++) begin
      r = $random(seed);
      imm[i] = r[11:0];
      place(base + 4 * i, i_type(rv_core_pkg::op_imm, rd[i], rs1[i], imm[i]));
    end
    wait_for_pc(base);
    for (i = 0; i < 5; i++) begin
      expect_write(rd[i] != 5'd0, rd[i], model[rs1[i]] + sext12(imm[i]));
      advance_to(base + 4 * (i + 1));
    end
  endtask

  task automatic upper_imm();
    logic [31:0] base;
    logic [31:0] r;
    logic [19:0] hi_a;
    logic [19:0] hi_b;
    r = $random(seed);
    hi_a = r[31:12];
    r = $random(seed);
    hi_b = r[31:12];
    base = pc + 8;
    place(base, u_type(rv_core_pkg::op_lui, 5'd7, hi_a));
    place(base + 4, u_type(rv_core_pkg::op_auipc, 5'd8, hi_b));
    wait_for_pc(base);
    expect_write(1'b1, 5'd7, {hi_a, 12'h000});
    advance_to(base + 4);
    // auipc adds to its own pc
    expect_write(1'b1, 5'd8, base + 4 + {hi_b, 12'h000});
    advance_to(base + 8);
  endtask

  task automatic jal_jumps();
    logic [31:0] base;
    base = pc + 8;
    place(base, j_type(5'd1, 21'd40));
    // jump of -36 back to base + 4
    place(base + 40, j_type(5'd2, 21'h1f_ffdc));
    wait_for_pc(base);
    expect_write(1'b1, 5'd1, base + 4);
    advance_to(base + 40);
    expect_write(1'b1, 5'd2, base + 44);
    advance_to(base + 40 - 36);
    // the walk passes base + 40 again
    place(base + 40, i_type(rv_core_pkg::op_imm, 5'd0, 5'd0, 12'd0));
  endtask

  task automatic jalr_jump();
    logic [31:0] base;
    logic [31:0] value;
    logic [11:0] lo;
    logic [19:0] hi;
    base = pc + 8;
    value = base + 60;
    // lui part compensates for the sign of the addi part
    lo = value[11:0];
    hi = value[31:12] + {19'd0, lo[11]};
    place(base, u_type(rv_core_pkg::op_lui, 5'd9, hi));
    place(base + 4, i_type(rv_core_pkg::op_imm, 5'd9, 5'd9, lo));
    // odd offset so that bit 0 of the sum gets dropped
    place(base + 8, i_type(rv_core_pkg::op_jalr, 5'd3, 5'd9, 12'd5));
    wait_for_pc(base);
    expect_write(1'b1, 5'd9, {hi, 12'h000});
    advance_to(base + 4);
    expect_write(1'b1, 5'd9, value);
    advance_to(base + 8);
    expect_write(1'b1, 5'd3, base + 12);
    advance_to((value + 32'd5) & ~32'd1);
  endtask

  task automatic ebreak_halt();
    logic [31:0] base;
    integer      i;
    base = pc + 8;
    place(base, i_type(rv_core_pkg::op_system, 5'd0, 5'd0, 12'h001));
    wait_for_pc(base);
    compare("halt", halt, 1'b0);
    compare("rd_wen", rd_wen, 1'b0);
    next_cycle();
    compare("halt", halt, 1'b1);
    compare("pc", pc, base);
    // a live addi at the frozen pc must not write
    place(base, i_type(rv_core_pkg::op_imm, 5'd10, 5'd0, 12'd5));
    for (i = 0; i < 4; i++) begin
      next_cycle();
      compare("pc", pc, base);
      compare("halt", halt, 1'b1);
      compare("rd_wen", rd_wen, 1'b0);
    end
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    #3;
    compare("pc", pc, rv_core_pkg::reset_pc);
    compare("halt", halt, 1'b0);
    advance_to(rv_core_pkg::reset_pc + 4);
  endtask

  initial begin
    integer i;
    seed = 32'h6ce5ccdd;
    errors = 0;
    timeouts = 0;
    clk = 1'b0;
    reset = 1'b1;
    inst = i_type(rv_core_pkg::op_imm, 5'd0, 5'd0, 12'd0);
    for (i = 0; i < 256; i++) begin
      image[i] = i_type(rv_core_pkg::op_imm, 5'd0, 5'd0, 12'd0);
    end
    for (i = 0; i < 32; i++) begin
      model[i] = 32'd0;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    #3;
    reset_state();
    addi_chain();
    upper_imm();
    jal_jumps();
    jalr_jump();
    ebreak_halt();
    $display("check failures: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rv_core_top.sv
module rv_core_top (
  input  logic                               clk,
  input  logic                               reset,
  // instruction at the current pc
  input  logic [31:0]                        inst,
  output logic [rv_core_pkg::xlen-1:0]       pc,
  // write that commits at the next rising edge
  output logic                               rd_wen,
  output logic [rv_core_pkg::reg_addr_w-1:0] rd_addr,
  output logic [rv_core_pkg::xlen-1:0]       rd_data,
  output logic                               halt
);

  // decode outputs
  logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_core_pkg::xlen-1:0]       imm;
  rv_core_pkg::src1_sel_t             src1_sel;
  rv_core_pkg::wb_sel_t               wb_sel;
  logic                               wr_en;
  logic                               is_jump;
  logic                               is_jalr;
  logic                               is_ebreak;

  // datapath
  logic [rv_core_pkg::xlen-1:0] rs1_data;
  logic [rv_core_pkg::xlen-1:0] target;
  logic [rv_core_pkg::xlen-1:0] wdata;
  logic                         commit;

  inst_decode i_decode (
    .inst      (inst),
    .rs1_addr  (rs1_addr),
    .rd_addr   (rd_addr),
    .imm       (imm),
    .src1_sel  (src1_sel),
    .wb_sel    (wb_sel),
    .wr_en     (wr_en),
    .is_jump   (is_jump),
    .is_jalr   (is_jalr),
    .is_ebreak (is_ebreak)
  );

  // no writes once halted
  assign rd_wen  = wr_en & commit;
  assign rd_data = wdata;

  reg_file i_reg_file (
    .clk   (clk),
    .wen   (rd_wen),
    .waddr (rd_addr),
    .wdata (wdata),
    .raddr (rs1_addr),
    .rdata (rs1_data)
  );

  exec_unit i_exec (
    .pc       (pc),
    .rs1_data (rs1_data),
    .imm      (imm),
    .src1_sel (src1_sel),
    .wb_sel   (wb_sel),
    .is_jalr  (is_jalr),
    .target   (target),
    .wdata    (wdata)
  );

  pc_unit i_pc (
    .clk       (clk),
    .reset     (reset),
    .is_jump   (is_jump),
    .is_ebreak (is_ebreak),
    .target    (target),
    .pc        (pc),
    .halt      (halt),
    .commit    (commit)
  );

endmodule

// File: pc_unit.sv
module pc_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         is_jump,
  input  logic                         is_ebreak,
  input  logic [rv_core_pkg::xlen-1:0] target,
  output logic [rv_core_pkg::xlen-1:0] pc,
  output logic                         halt,
  // low once halted, gates register writes at the top
  output logic                         commit
);

  logic                         halted;
  logic [rv_core_pkg::xlen-1:0] pc_plus4;
  logic [rv_core_pkg::xlen-1:0] pc_next;

  // next pc select
  assign pc_plus4 = pc + rv_core_pkg::xlen'(4);
  assign pc_next  = is_jump ? target : pc_plus4;

  // pc register and sticky halt flag
  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= rv_core_pkg::reset_pc;
      halted <= 1'b0;
    end else begin
      // ebreak freezes the pc on its own address
      if (commit && !is_ebreak) begin
        pc <= pc_next;
      end
      // only cleared by reset
      if (commit && is_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  assign halt   = halted;
  assign commit = ~halted;

  // targets come from the adder, so alignment depends on the program
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else $error("pc_unit: misaligned pc %h", pc);

endmodule

// File: exec_unit.sv
module exec_unit (
  input  logic [rv_core_pkg::xlen-1:0] pc,
  input  logic [rv_core_pkg::xlen-1:0] rs1_data,
  input  logic [rv_core_pkg::xlen-1:0] imm,
  input  rv_core_pkg::src1_sel_t       src1_sel,
  input  rv_core_pkg::wb_sel_t         wb_sel,
  input  logic                         is_jalr,
  // jump target for the pc unit
  output logic [rv_core_pkg::xlen-1:0] target,
  // write-back data
  output logic [rv_core_pkg::xlen-1:0] wdata
);

  logic [rv_core_pkg::xlen-1:0] src1;
  logic [rv_core_pkg::xlen-1:0] sum;
  logic [rv_core_pkg::xlen-1:0] link;

  // first adder operand
  always_comb begin
    case (src1_sel)
      rv_core_pkg::src1_reg: src1 = rs1_data;
      rv_core_pkg::src1_pc:  src1 = pc;
      default:               src1 = '0;
    endcase
  end

  // one adder serves addi, lui, auipc and both jumps
  assign sum = src1 + imm;

  // jalr drops bit 0 of the computed address
  assign target = is_jalr ? {sum[rv_core_pkg::xlen-1:1], 1'b0} : sum;

  // return address
  assign link = pc + rv_core_pkg::xlen'(4);

  // write-back select
  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_link: wdata = link;
      default:              wdata = sum;
    endcase
  end

endmodule

// File: inst_decode.sv
module inst_decode (
  input  logic [31:0]                        inst,
  // register addresses
  output logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_core_pkg::reg_addr_w-1:0] rd_addr,
  // immediate for the adder
  output logic [rv_core_pkg::xlen-1:0]       imm,
  // datapath control
  output rv_core_pkg::src1_sel_t             src1_sel,
  output rv_core_pkg::wb_sel_t               wb_sel,
  output logic                               wr_en,
  // pc control
  output logic                               is_jump,
  output logic                               is_jalr,
  output logic                               is_ebreak
);

  rv_core_pkg::opcode_t opcode;
  logic [2:0]           funct3;

  // immediates, all sign extended to xlen
  logic [rv_core_pkg::xlen-1:0] imm_i;
  logic [rv_core_pkg::xlen-1:0] imm_u;
  logic [rv_core_pkg::xlen-1:0] imm_j;

  // write request before the x0 filter
  logic wr_op;

  // fixed field positions
  assign opcode   = rv_core_pkg::opcode_t'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rd_addr  = inst[11:7];

  // I-type, inst[31:20]
  assign imm_i = {{(rv_core_pkg::xlen-12){inst[31]}}, inst[31:20]};
  // U-type, upper 20 bits already in place
  assign imm_u = {inst[31:12], 12'b0};
  // J-type, scrambled offset with implicit bit 0
  assign imm_j = {{(rv_core_pkg::xlen-21){inst[31]}},
                  inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // per-opcode control
  always_comb begin
    // defaults behave as a nop: no write, pc + 4
    src1_sel  = rv_core_pkg::src1_reg;
    wb_sel    = rv_core_pkg::wb_sum;
    imm       = imm_i;
    wr_op     = 1'b0;
    is_jump   = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      rv_core_pkg::op_imm: begin
        // addi
        wr_op = (funct3 == 3'b000);
      end
      rv_core_pkg::op_lui: begin
        src1_sel = rv_core_pkg::src1_zero;
        imm      = imm_u;
        wr_op    = 1'b1;
      end
      rv_core_pkg::op_auipc: begin
        src1_sel = rv_core_pkg::src1_pc;
        imm      = imm_u;
        wr_op    = 1'b1;
      end
      rv_core_pkg::op_jal: begin
        src1_sel = rv_core_pkg::src1_pc;
        imm      = imm_j;
        wb_sel   = rv_core_pkg::wb_link;
        wr_op    = 1'b1;
        is_jump  = 1'b1;
      end
      rv_core_pkg::op_jalr: begin
        // rs1 + imm_i, funct3 must be zero
        if (funct3 == 3'b000) begin
          wb_sel  = rv_core_pkg::wb_link;
          wr_op   = 1'b1;
          is_jump = 1'b1;
          is_jalr = 1'b1;
        end
      end
      rv_core_pkg::op_system: begin
        // ebreak: funct12 = 1, rs1, funct3 and rd all zero
        is_ebreak = (inst[31:20] == 12'h001) && (inst[19:7] == 13'h0);
      end
      default: begin
        // unknown opcode, keep the nop defaults
      end
    endcase
  end

  // x0 destination never writes
  assign wr_en = wr_op && (rd_addr != '0);

endmodule

// File: reg_file.sv
module reg_file (
  input  logic                               clk,
  // write port, commits at the rising edge
  input  logic                               wen,
  input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_core_pkg::xlen-1:0]       wdata,
  // single read port, rs1 only
  input  logic [rv_core_pkg::reg_addr_w-1:0] raddr,
  output logic [rv_core_pkg::xlen-1:0]       rdata
);

  // register array
  // entry 0 is never written, reads of x0 are forced to zero below
  logic [rv_core_pkg::xlen-1:0] regs [0:rv_core_pkg::num_regs-1];

  // synchronous write
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read
  // a write in this cycle shows up only after the edge
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

  // decode already drops writes to x0
  // so a write strobe aimed at entry 0 means the decoder broke
  a_no_x0_write: assert property (
    @(posedge clk) wen |-> (waddr != '0)
  ) else $error("reg_file: write strobe with waddr == 0");

endmodule

// File: rv_core_pkg.sv
package rv_core_pkg;

  // data and address width
  localparam int xlen = 32;

  // register file geometry
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes in scope, inst[6:0]
  typedef enum logic [6:0] {
    // addi only, other funct3 values are not decoded
    op_imm    = 7'b001_0011,
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    // only ebreak is recognised here
    op_system = 7'b111_0011
  } opcode_t;

  // write-back data select
  typedef enum logic [1:0] {
    // adder result
    wb_sum  = 2'd0,
    // return address, pc + 4
    wb_link = 2'd1
  } wb_sel_t;

  // adder first operand select
  typedef enum logic [1:0] {
    src1_reg  = 2'd0,
    src1_pc   = 2'd1,
    // lui passes the immediate straight through
    src1_zero = 2'd2
  } src1_sel_t;

endpackage
